// File: src/mem_wb_pkg.sv
package mem_wb_pkg;

    // Datapath and register file geometry
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Byte lanes within one data word
    localparam int BE_W       = XLEN / 8;
    localparam int BYTE_OFF_W = $clog2(BE_W);

    // Data RAM, word addressed, upper address bits wrap
    localparam int RAM_WORDS  = 256;
    localparam int RAM_ADDR_W = $clog2(RAM_WORDS);

    // Memory operation issued by execute
    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,   // No memory access
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    // Access width
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    // Source of the register file write data
    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,     // Execute result
        WB_MEM  = 2'd1,     // Extended load data
        WB_LINK = 2'd2      // Return address for jumps
    } wb_sel_e;

endpackage

// File: src/dmem_if.sv
`timescale 1ns/1ps

interface dmem_if import mem_wb_pkg::*;;

    logic [RAM_ADDR_W-1:0] addr;    // Word index
    logic [XLEN-1:0]       wdata;   // Lane-replicated store data
    logic [BE_W-1:0]       be;      // Byte enables
    logic                  we;      // Write strobe for this edge
    logic [XLEN-1:0]       rdata;   // Word at last edge's addr

    // Memory stage side
    modport master (
        output addr,
        output wdata,
        output be,
        output we,
        input  rdata
    );

    // RAM side
    modport slave (
        input  addr,
        input  wdata,
        input  be,
        input  we,
        output rdata
    );

endinterface

// File: src/mem_stage.sv
`timescale 1ns/1ps

module mem_stage import mem_wb_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  ex_valid,
    input  logic [XLEN-1:0]       ex_alu_result,
    input  logic [XLEN-1:0]       ex_store_data,
    input  logic [XLEN-1:0]       ex_link_value,
    input  mem_op_e               ex_mem_op,
    input  mem_size_e             ex_mem_size,
    input  logic                  ex_load_unsigned,
    input  wb_sel_e               ex_wb_sel,
    input  logic                  ex_reg_write,
    input  logic [REG_ADDR_W-1:0] ex_rd,

    dmem_if.master                dmem,

    output logic                  m_valid,
    output logic [XLEN-1:0]       m_alu_result,
    output logic [XLEN-1:0]       m_link_value,
    output mem_op_e               m_mem_op,
    output mem_size_e             m_size,
    output logic                  m_unsigned,
    output logic [BYTE_OFF_W-1:0] m_offset,
    output wb_sel_e               m_wb_sel,
    output logic                  m_reg_write,
    output logic [REG_ADDR_W-1:0] m_rd,
    output logic                  m_misaligned
);

    logic [XLEN-1:0] store_data;    // Raw store operand from execute
    logic            access;        // Valid load or store in this stage
    logic            bad_align;

    // Execute to memory pipeline register
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            m_valid      <= 1'b0;
            m_alu_result <= '0;
            store_data   <= '0;
            m_link_value <= '0;
            m_mem_op     <= MEM_NONE;
            m_size       <= SIZE_BYTE;
            m_unsigned   <= 1'b0;
            m_wb_sel     <= WB_ALU;
            m_reg_write  <= 1'b0;
            m_rd         <= '0;
        end
        else
        begin
            m_valid      <= ex_valid;
            m_alu_result <= ex_alu_result;
            store_data   <= ex_store_data;
            m_link_value <= ex_link_value;
            m_mem_op     <= ex_mem_op;
            m_size       <= ex_mem_size;
            m_unsigned   <= ex_load_unsigned;
            m_wb_sel     <= ex_wb_sel;
            m_reg_write  <= ex_reg_write;
            m_rd         <= ex_rd;
        end
    end

    assign m_offset = m_alu_result[BYTE_OFF_W-1:0];
    assign access   = m_valid && (m_mem_op != MEM_NONE);

    // Natural alignment check on the registered address
    always_comb
    begin
        case (m_size)
            SIZE_BYTE: bad_align = 1'b0;
            SIZE_HALF: bad_align = m_offset[0];
            default:   bad_align = |m_offset;   // Word
        endcase
    end

    assign m_misaligned = access && bad_align;

    // Word index only, so accesses wrap around the RAM
    assign dmem.addr = m_alu_result[RAM_ADDR_W+BYTE_OFF_W-1:BYTE_OFF_W];

    // Lane replication and byte enables
    always_comb
    begin
        case (m_size)
            SIZE_BYTE:
            begin
                dmem.wdata = {BE_W{store_data[7:0]}};
                dmem.be    = BE_W'(1) << m_offset;
            end
            SIZE_HALF:
            begin
                dmem.wdata = {(BE_W/2){store_data[15:0]}};
                dmem.be    = m_offset[1] ? 4'b1100 : 4'b0011;
            end
            default:
            begin
                dmem.wdata = store_data;
                dmem.be    = '1;
            end
        endcase
    end

    // Misaligned stores never reach the array
    assign dmem.we = access && (m_mem_op == MEM_STORE) && !bad_align;

endmodule

// File: src/data_ram.sv
`timescale 1ns/1ps

module data_ram import mem_wb_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    dmem_if.slave  dmem
);

    logic [XLEN-1:0] mem [RAM_WORDS];

    // Byte-lane writes
    always_ff @(posedge clk)
    begin
        if (dmem.we)
        begin
            for (int i = 0; i < BE_W; i++)
            begin
                if (dmem.be[i])
                begin
                    mem[dmem.addr][i*8 +: 8] <= dmem.wdata[i*8 +: 8];
                end
            end
        end
    end

    // Registered read, old data on a same-edge write
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            dmem.rdata <= '0;
        end
        else
        begin
            dmem.rdata <= mem[dmem.addr];
        end
    end

endmodule

// File: src/wb_stage.sv
`timescale 1ns/1ps

module wb_stage import mem_wb_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  m_valid,
    input  logic [XLEN-1:0]       m_alu_result,
    input  logic [XLEN-1:0]       m_link_value,
    input  mem_op_e               m_mem_op,
    input  mem_size_e             m_size,
    input  logic                  m_unsigned,
    input  logic [BYTE_OFF_W-1:0] m_offset,
    input  wb_sel_e               m_wb_sel,
    input  logic                  m_reg_write,
    input  logic [REG_ADDR_W-1:0] m_rd,
    input  logic                  m_misaligned,

    input  logic [XLEN-1:0]       ram_rdata,

    output logic                  wb_valid,
    output logic                  wb_we,
    output logic [REG_ADDR_W-1:0] wb_rd,
    output logic [XLEN-1:0]       wb_data,
    output logic                  wb_misaligned
);

    logic [XLEN-1:0]       alu_result_q;
    logic [XLEN-1:0]       link_value_q;
    mem_op_e               mem_op_q;
    mem_size_e             size_q;
    logic                  unsigned_q;
    logic [BYTE_OFF_W-1:0] offset_q;
    wb_sel_e               wb_sel_q;
    logic                  reg_write_q;

    logic [XLEN-1:0]       lane;        // Read word shifted to lane 0
    logic [XLEN-1:0]       load_data;

    // Memory to writeback pipeline register
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wb_valid      <= 1'b0;
            alu_result_q  <= '0;
            link_value_q  <= '0;
            mem_op_q      <= MEM_NONE;
            size_q        <= SIZE_BYTE;
            unsigned_q    <= 1'b0;
            offset_q      <= '0;
            wb_sel_q      <= WB_ALU;
            reg_write_q   <= 1'b0;
            wb_rd         <= '0;
            wb_misaligned <= 1'b0;
        end
        else
        begin
            wb_valid      <= m_valid;
            alu_result_q  <= m_alu_result;
            link_value_q  <= m_link_value;
            mem_op_q      <= m_mem_op;
            size_q        <= m_size;
            unsigned_q    <= m_unsigned;
            offset_q      <= m_offset;
            wb_sel_q      <= m_wb_sel;
            reg_write_q   <= m_reg_write;
            wb_rd         <= m_rd;
            wb_misaligned <= m_misaligned;
        end
    end

    assign lane = ram_rdata >> {offset_q, 3'b000};

    // Sign or zero extension of the addressed lane
    always_comb
    begin
        case (size_q)
            SIZE_BYTE: load_data = {{(XLEN-8){lane[7] & ~unsigned_q}}, lane[7:0]};
            SIZE_HALF: load_data = {{(XLEN-16){lane[15] & ~unsigned_q}}, lane[15:0]};
            default:   load_data = ram_rdata;
        endcase
    end

    // Writeback source select
    always_comb
    begin
        case (wb_sel_q)
            WB_MEM:  wb_data = (mem_op_q == MEM_LOAD) ? load_data : '0;  // Only loads read RAM
            WB_LINK: wb_data = link_value_q;
            default: wb_data = alu_result_q;
        endcase
    end

    assign wb_we = wb_valid && reg_write_q && !wb_misaligned;

endmodule

// File: src/mem_wb_top.sv
`timescale 1ns/1ps

module mem_wb_top import mem_wb_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  ex_valid,
    input  logic [XLEN-1:0]       ex_alu_result,
    input  logic [XLEN-1:0]       ex_store_data,
    input  logic [XLEN-1:0]       ex_link_value,
    input  mem_op_e               ex_mem_op,
    input  mem_size_e             ex_mem_size,
    input  logic                  ex_load_unsigned,
    input  wb_sel_e               ex_wb_sel,
    input  logic                  ex_reg_write,
    input  logic [REG_ADDR_W-1:0] ex_rd,

    output logic                  wb_valid,
    output logic                  wb_we,
    output logic [REG_ADDR_W-1:0] wb_rd,
    output logic [XLEN-1:0]       wb_data,
    output logic                  wb_misaligned
);

    // Memory stage outputs
    logic                  m_valid;
    logic [XLEN-1:0]       m_alu_result;
    logic [XLEN-1:0]       m_link_value;
    mem_op_e               m_mem_op;
    mem_size_e             m_size;
    logic                  m_unsigned;
    logic [BYTE_OFF_W-1:0] m_offset;
    wb_sel_e               m_wb_sel;
    logic                  m_reg_write;
    logic [REG_ADDR_W-1:0] m_rd;
    logic                  m_misaligned;

    dmem_if dmem ();

    mem_stage u_mem_stage (
        .clk              (clk),
        .rst              (rst),
        .ex_valid         (ex_valid),
        .ex_alu_result    (ex_alu_result),
        .ex_store_data    (ex_store_data),
        .ex_link_value    (ex_link_value),
        .ex_mem_op        (ex_mem_op),
        .ex_mem_size      (ex_mem_size),
        .ex_load_unsigned (ex_load_unsigned),
        .ex_wb_sel        (ex_wb_sel),
        .ex_reg_write     (ex_reg_write),
        .ex_rd            (ex_rd),
        .dmem             (dmem.master),
        .m_valid          (m_valid),
        .m_alu_result     (m_alu_result),
        .m_link_value     (m_link_value),
        .m_mem_op         (m_mem_op),
        .m_size           (m_size),
        .m_unsigned       (m_unsigned),
        .m_offset         (m_offset),
        .m_wb_sel         (m_wb_sel),
        .m_reg_write      (m_reg_write),
        .m_rd             (m_rd),
        .m_misaligned     (m_misaligned)
    );

    data_ram u_data_ram (
        .clk  (clk),
        .rst  (rst),
        .dmem (dmem.slave)
    );

    wb_stage u_wb_stage (
        .clk           (clk),
        .rst           (rst),
        .m_valid       (m_valid),
        .m_alu_result  (m_alu_result),
        .m_link_value  (m_link_value),
        .m_mem_op      (m_mem_op),
        .m_size        (m_size),
        .m_unsigned    (m_unsigned),
        .m_offset      (m_offset),
        .m_wb_sel      (m_wb_sel),
        .m_reg_write   (m_reg_write),
        .m_rd          (m_rd),
        .m_misaligned  (m_misaligned),
        .ram_rdata     (dmem.rdata),    // Read-only tap on the RAM port
        .wb_valid      (wb_valid),
        .wb_we         (wb_we),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .wb_misaligned (wb_misaligned)
    );

endmodule

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 4;

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Clean rising edge so the async reset fires at once
    initial
    begin
        rst = 1'b0;
        #1 rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: tb/mem_wb_tb.sv
`timescale 1ns/1ps

module mem_wb_tb import mem_wb_pkg::*;;

    localparam int CLK_PERIOD = 10;
    localparam int SEED       = 97;
    localparam int N_DIRECTED = 44;         // Directed issue cycles, fill included
    localparam int N_RANDOM   = 150;
    localparam int N_OPS      = N_DIRECTED + N_RANDOM;
    localparam int MEM_BYTES  = RAM_WORDS * BE_W;
    localparam int WIN_BYTES  = 64;         // Address window shared by loads and stores

    typedef struct {
        time                   t;           // Issue edge
        logic                  valid;
        logic                  we;
        logic                  mis;
        logic                  check;       // Data is defined for this slot
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } exp_rec_t;

    logic                  clk;
    logic                  rst;
    logic                  ex_valid;
    logic [XLEN-1:0]       ex_alu_result;
    logic [XLEN-1:0]       ex_store_data;
    logic [XLEN-1:0]       ex_link_value;
    mem_op_e               ex_mem_op;
    mem_size_e             ex_mem_size;
    logic                  ex_load_unsigned;
    wb_sel_e               ex_wb_sel;
    logic                  ex_reg_write;
    logic [REG_ADDR_W-1:0] ex_rd;
    logic                  wb_valid;
    logic                  wb_we;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;
    logic                  wb_misaligned;

    logic [7:0]            ram_model [MEM_BYTES];
    exp_rec_t              exp_q [$];
    exp_rec_t              head;
    logic                  exp_valid = 1'b0;
    logic                  exp_we    = 1'b0;
    logic                  exp_mis   = 1'b0;
    logic                  exp_check = 1'b0;
    logic [REG_ADDR_W-1:0] exp_rd    = '0;
    logic [XLEN-1:0]       exp_data  = '0;

    tb_clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    mem_wb_top u_mem_wb_top (
        .clk              (clk),
        .rst              (rst),
        .ex_valid         (ex_valid),
        .ex_alu_result    (ex_alu_result),
        .ex_store_data    (ex_store_data),
        .ex_link_value    (ex_link_value),
        .ex_mem_op        (ex_mem_op),
        .ex_mem_size      (ex_mem_size),
        .ex_load_unsigned (ex_load_unsigned),
        .ex_wb_sel        (ex_wb_sel),
        .ex_reg_write     (ex_reg_write),
        .ex_rd            (ex_rd),
        .wb_valid         (wb_valid),
        .wb_we            (wb_we),
        .wb_rd            (wb_rd),
        .wb_data          (wb_data),
        .wb_misaligned    (wb_misaligned)
    );

    function automatic int size_bytes(input mem_size_e size);
        case (size)
            SIZE_BYTE: return 1;
            SIZE_HALF: return 2;
            default:   return 4;
        endcase
    endfunction

    // Address dependent pattern for the initial window contents
    function automatic logic [XLEN-1:0] fill_word(input logic [XLEN-1:0] addr);
        return {~addr[15:0], addr[15:0]};
    endfunction

    // Little-endian read of the model, then sign or zero extension
    function automatic logic [XLEN-1:0] load_value(input logic [XLEN-1:0] addr,
                                                   input mem_size_e size, input logic uns);
        logic [XLEN-1:0] w;
        int              n;
        n = size_bytes(size);
        w = '0;
        for (int k = 0; k < n; k++)
        begin
            w[8*k +: 8] = ram_model[(addr + k) % MEM_BYTES];
        end
        if (n == 1)
            w = uns ? {24'b0, w[7:0]} : {{24{w[7]}}, w[7:0]};
        else if (n == 2)
            w = uns ? {16'b0, w[15:0]} : {{16{w[15]}}, w[15:0]};
        return w;
    endfunction

    task automatic value_error(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        $display("TEST FAILED");
        $fatal(1, "Writeback mismatch on %s", name);
    endtask

    // Drive one instruction and record its expected writeback
    task automatic issue(input logic v, input mem_op_e op, input mem_size_e size,
                         input logic uns, input wb_sel_e sel, input logic rw,
                         input logic [REG_ADDR_W-1:0] rd, input logic [XLEN-1:0] alu,
                         input logic [XLEN-1:0] sdata, input logic [XLEN-1:0] link);
        exp_rec_t rec;
        logic     bad;
        @(posedge clk);
        ex_valid         <= v;
        ex_alu_result    <= alu;
        ex_store_data    <= sdata;
        ex_link_value    <= link;
        ex_mem_op        <= op;
        ex_mem_size      <= size;
        ex_load_unsigned <= uns;
        ex_wb_sel        <= sel;
        ex_reg_write     <= rw;
        ex_rd            <= rd;
        bad = (size == SIZE_HALF && alu[0]) || (size == SIZE_WORD && alu[1:0] != 2'b00);
        rec.t     = $time;
        rec.valid = v;
        rec.mis   = v && (op != MEM_NONE) && bad;
        rec.we    = v && rw && !rec.mis;
        rec.check = v && !rec.mis;
        rec.rd    = rd;
        case (sel)
            WB_MEM:  rec.data = load_value(alu, size, uns);
            WB_LINK: rec.data = link;
            default: rec.data = alu;
        endcase
        if (v && op == MEM_STORE && !rec.mis)
        begin
            for (int k = 0; k < size_bytes(size); k++)
                ram_model[(alu + k) % MEM_BYTES] = sdata[8*k +: 8];
        end
        exp_q.push_back(rec);
    endtask

    task automatic store(input mem_size_e size, input logic [XLEN-1:0] addr,
                         input logic [XLEN-1:0] data);
        issue(1'b1, MEM_STORE, size, 1'b0, WB_ALU, 1'b0, '0, addr, data, '0);
    endtask

    task automatic load(input mem_size_e size, input logic uns, input logic [XLEN-1:0] addr,
                        input logic [REG_ADDR_W-1:0] rd);
        issue(1'b1, MEM_LOAD, size, uns, WB_MEM, 1'b1, rd, addr, '0, '0);
    endtask

    task automatic reg_op(input wb_sel_e sel, input logic rw, input logic [REG_ADDR_W-1:0] rd,
                          input logic [XLEN-1:0] alu, input logic [XLEN-1:0] link);
        issue(1'b1, MEM_NONE, SIZE_WORD, 1'b0, sel, rw, rd, alu, '0, link);
    endtask

    task automatic idle();
        @(posedge clk);
        ex_valid <= 1'b0;
    endtask

    // Retire each record two edges after its issue
    always @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            exp_valid <= 1'b0;
            exp_we    <= 1'b0;
            exp_mis   <= 1'b0;
            exp_check <= 1'b0;
        end
        else if (exp_q.size() != 0 && exp_q[0].t == $time - 2 * CLK_PERIOD)
        begin
            head = exp_q.pop_front();
            exp_valid <= head.valid;
            exp_we    <= head.we;
            exp_mis   <= head.mis;
            exp_check <= head.check;
            exp_rd    <= head.rd;
            exp_data  <= head.data;
        end
        else
        begin
            exp_valid <= 1'b0;    // Bubble
            exp_we    <= 1'b0;
            exp_mis   <= 1'b0;
            exp_check <= 1'b0;
        end
    end

    assert property (@(posedge clk) wb_valid === exp_valid)
        else value_error("wb_valid", $sampled(wb_valid), $sampled(exp_valid));
    assert property (@(posedge clk) wb_we === exp_we)
        else value_error("wb_we", $sampled(wb_we), $sampled(exp_we));
    assert property (@(posedge clk) wb_misaligned === exp_mis)
        else value_error("wb_misaligned", $sampled(wb_misaligned), $sampled(exp_mis));
    assert property (@(posedge clk) !exp_valid || (wb_rd === exp_rd))
        else value_error("wb_rd", $sampled(wb_rd), $sampled(exp_rd));
    assert property (@(posedge clk) !exp_check || (wb_data === exp_data))
        else value_error("wb_data", $sampled(wb_data), $sampled(exp_data));

    initial
    begin
        #((N_OPS + 20) * CLK_PERIOD);
        $display("Simulation did not finish in the expected number of cycles");
        $display("TEST FAILED");
        $fatal(1, "Watchdog timeout");
    end

    initial
    begin
        logic [XLEN-1:0]       addr;
        logic [XLEN-1:0]       hi;
        logic [XLEN-1:0]       data;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rw;
        logic                  uns;
        mem_size_e             size;
        int                    kind;
        void'($urandom(SEED));
        ex_valid         = 1'b0;
        ex_alu_result    = '0;
        ex_store_data    = '0;
        ex_link_value    = '0;
        ex_mem_op        = MEM_NONE;
        ex_mem_size      = SIZE_BYTE;
        ex_load_unsigned = 1'b0;
        ex_wb_sel        = WB_ALU;
        ex_reg_write     = 1'b0;
        ex_rd            = '0;
        wait (rst === 1'b1);
        wait (rst === 1'b0);

        for (int w = 0; w < WIN_BYTES / 4; w++)
            store(SIZE_WORD, w * 4, fill_word(w * 4));

        // Word store then load, back to back through an aliased address
        store(SIZE_WORD, 32'h20, 32'hDEAD_BEEF);
        load(SIZE_WORD, 1'b0, 32'h420, 5'd1);
        store(SIZE_WORD, 32'h24, 32'h1234_5678);
        idle();
        load(SIZE_WORD, 1'b0, 32'h24, 5'd2);

        // Partial stores merge into the word
        store(SIZE_BYTE, 32'h29, 32'hFFFF_FF5A);
        store(SIZE_HALF, 32'h2E, 32'h1234_BEEF);
        store(SIZE_BYTE, 32'h2C, 32'h0000_0081);
        load(SIZE_WORD, 1'b0, 32'h28, 5'd3);
        load(SIZE_WORD, 1'b0, 32'h2C, 5'd4);

        load(SIZE_BYTE, 1'b0, 32'h20, 5'd5);
        load(SIZE_BYTE, 1'b1, 32'h20, 5'd6);
        load(SIZE_BYTE, 1'b0, 32'h23, 5'd7);
        load(SIZE_HALF, 1'b0, 32'h22, 5'd8);
        load(SIZE_HALF, 1'b1, 32'h22, 5'd9);
        load(SIZE_HALF, 1'b0, 32'h24, 5'd10);
        load(SIZE_BYTE, 1'b1, 32'h26, 5'd11);

        reg_op(WB_ALU, 1'b1, 5'd5, 32'hA5A5_0001, 32'h100);
        reg_op(WB_LINK, 1'b1, 5'd31, 32'h2, 32'h1004);
        reg_op(WB_ALU, 1'b0, 5'd7, 32'h3, 32'h4);
        reg_op(WB_LINK, 1'b0, 5'd0, 32'h5, 32'h6);

        // Misaligned accesses, then aligned reads of the same words
        store(SIZE_WORD, 32'h31, 32'hFFFF_FFFF);
        store(SIZE_HALF, 32'h33, 32'h0000_FFFF);
        load(SIZE_WORD, 1'b0, 32'h32, 5'd12);
        load(SIZE_HALF, 1'b0, 32'h35, 5'd13);
        load(SIZE_WORD, 1'b0, 32'h30, 5'd14);
        load(SIZE_WORD, 1'b0, 32'h34, 5'd15);

        for (int i = 0; i < N_RANDOM; i++)
        begin
            kind = $urandom % 8;
            hi   = $urandom;
            addr = (hi & ~(MEM_BYTES - 1)) | ($urandom % WIN_BYTES);   // Upper bits wrap
            size = mem_size_e'($urandom % 3);
            data = $urandom;
            rd   = REG_ADDR_W'($urandom);
            rw   = 1'($urandom);
            uns  = 1'($urandom);
            if ($urandom % 4 != 0)
                addr = addr & ~(size_bytes(size) - 1);
            case (kind)
                0:       issue(1'b0, MEM_STORE, size, uns, WB_ALU, rw, rd, addr, data, hi);
                1, 2, 3: store(size, addr, data);
                4, 5, 6: load(size, uns, addr, rd);
                default: reg_op(rw ? WB_LINK : WB_ALU, uns, rd, addr, hi);
            endcase
        end
        idle();

        repeat (4) @(posedge clk);
        $display("TEST OK");
        $finish;
    end

endmodule

// File: sim.f
src/mem_wb_pkg.sv
src/dmem_if.sv
src/mem_stage.sv
src/data_ram.sv
src/wb_stage.sv
src/mem_wb_top.sv
tb/tb_clk_gen.sv
tb/mem_wb_tb.sv
